// File: rtl/rename_cfg.svh
// ==============================
// sizes for the rename stage
// include wherever a width or a count is needed
// ==============================
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// dispatch slots presented each cycle
`define RN_SLOTS    4
`define RN_AREGS    64
`define RN_AREG_W   6
`define RN_TAG_W    6
`define RN_RD_PORTS 2

// register 0 is always hard-wired, this is the second one
`define RN_ZERO_B   32

`endif

// File: rtl/rename_pkg.sv
// ==============================
// types for the rename source table
// register indices, ROB tags and table entries
// ==============================
`include "rename_cfg.svh"

package rename_pkg;

	// architectural register index
	typedef logic [`RN_AREG_W-1:0] areg_t;

	// reorder buffer tag
	typedef logic [`RN_TAG_W-1:0] rob_tag_t;

	// one source entry per architectural register
	// when in_rf is set the value sits in the register file and
	// half and tag are held at zero
	typedef struct packed {
		logic     in_rf;
		logic     half;
		rob_tag_t tag;
	} src_entry_t;

	// entry for a register whose value is in the register file
	localparam src_entry_t RF_ENTRY = '{
		in_rf: 1'b1,
		half:  1'b0,
		tag:   '0
	};

endpackage

// File: rtl/dispatch_pkg.sv
// ==============================
// types for dispatch slots and the
// per-slot map write requests
// ==============================

package dispatch_pkg;

	// one dispatch slot as it arrives from decode
	typedef struct packed {
		logic              valid;
		logic              queued;
		logic              rfw;
		rename_pkg::areg_t rd;
		rename_pkg::areg_t rd2;
	} slot_t;

	// write request for the rename map
	// rd2 of zero lands on hard-wired register 0
	typedef struct packed {
		logic                 en;
		rename_pkg::areg_t    rd;
		rename_pkg::areg_t    rd2;
		rename_pkg::rob_tag_t tag;
	} map_wr_t;

endpackage

// File: rtl/rename_ifs.sv
// ==============================
// interfaces between the tagger, the
// rename map and the operand lookup
// map_write_if carries registered slot writes
// map_read_if carries the combinational read ports
// ==============================
`timescale 1ns/1ps
`include "rename_cfg.svh"

interface map_write_if;

	dispatch_pkg::map_wr_t req [`RN_SLOTS];
	// flush level forwarded from the pipeline
	logic flush;

	modport tagger (
		output req,
		output flush
	);

	modport map (
		input req,
		input flush
	);

endinterface

interface map_read_if;

	rename_pkg::areg_t                addr  [`RN_RD_PORTS];
	logic             [`RN_RD_PORTS-1:0] in_rf;
	logic             [`RN_RD_PORTS-1:0] half;
	rename_pkg::rob_tag_t             tag   [`RN_RD_PORTS];

	modport lookup (
		output addr,
		input  in_rf,
		input  half,
		input  tag
	);

	modport map (
		input  addr,
		output in_rf,
		output half,
		output tag
	);

endinterface

// File: rtl/dispatch_tagger.sv
// ==============================
// assigns ROB tags to queued dispatch slots
// and registers one map write per slot
// requests reach the rename map one cycle later
// ==============================
`timescale 1ns/1ps
`include "rename_cfg.svh"

module dispatch_tagger (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  flush,
	input  dispatch_pkg::slot_t   slots [`RN_SLOTS],
	input  rename_pkg::rob_tag_t  rob_tail,
	output logic [2:0]            dispatch_count,
	map_write_if.tagger           wr
);

	logic [`RN_SLOTS-1:0]   accept;
	logic [`RN_SLOTS-1:0]   valid_vec;
	logic [2:0]             accept_cnt;
	rename_pkg::rob_tag_t   slot_tag [`RN_SLOTS];
	dispatch_pkg::map_wr_t  req_q [`RN_SLOTS];

	// ==============================
	// acceptance chain
	// ==============================
	// invalid slots are skipped, the first valid slot that is not
	// queued stops the walk for every slot above it
	always_comb begin
		logic       stop;
		logic [2:0] cnt;
		stop = 1'b0;
		cnt = '0;
		for (int i = 0; i < `RN_SLOTS; i++) begin
			valid_vec[i] = slots[i].valid;
			accept[i] = 1'b0;
			slot_tag[i] = rob_tail + rename_pkg::rob_tag_t'(cnt);
			if (slots[i].valid && !stop) begin
				if (slots[i].queued) begin
					accept[i] = 1'b1;
					cnt = cnt + 3'd1;
				end else begin
					stop = 1'b1;
				end
			end
		end
		accept_cnt = cnt;
	end

	// ==============================
	// request registers
	// ==============================
	always_ff @(posedge clk) begin
		// a flush drops whatever is dispatched in the same cycle
		if (rst || flush) begin
			dispatch_count <= '0;
			for (int i = 0; i < `RN_SLOTS; i++)
				req_q[i].en <= 1'b0;
		end else begin
			dispatch_count <= accept_cnt;
			for (int i = 0; i < `RN_SLOTS; i++)
				req_q[i].en <= accept[i] && slots[i].rfw;
		end
		for (int i = 0; i < `RN_SLOTS; i++) begin
			req_q[i].rd <= slots[i].rd;
			req_q[i].rd2 <= slots[i].rd2;
			req_q[i].tag <= slot_tag[i];
		end
	end

	assign wr.req = req_q;
	assign wr.flush = flush;

	// never more slots accepted than were valid on the cycle before
	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		32'(dispatch_count) <= $past($countones(valid_vec)))
		else $error("dispatch_count %0d above valid slot count", dispatch_count);

endmodule

// File: rtl/rename_map.sv
// ==============================
// rename source table, one entry per register
// updated by commit, slot writes and flush
// read ports are combinational
// ==============================
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_map (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 commit_valid,
	input  rename_pkg::rob_tag_t commit_tag,
	map_write_if.map             wr,
	map_read_if.map              rd
);

	rename_pkg::src_entry_t src [`RN_AREGS];

	// ==============================
	// table update
	// ==============================
	// later assignments win, so the order below is the priority
	// from lowest to highest
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `RN_AREGS; r++)
				src[r] <= rename_pkg::RF_ENTRY;
		end else begin
			// commit returns registers still waiting on this tag
			if (commit_valid) begin
				for (int r = 0; r < `RN_AREGS; r++) begin
					if (!src[r].in_rf && src[r].tag == commit_tag)
						src[r] <= rename_pkg::RF_ENTRY;
				end
			end

			// slot writes in ascending order, rd before rd2
			// an unused rd2 is zero and gets overwritten by the forcing below
			for (int s = 0; s < `RN_SLOTS; s++) begin
				if (wr.req[s].en) begin
					src[wr.req[s].rd] <= '{
						in_rf: 1'b0,
						half:  1'b0,
						tag:   wr.req[s].tag
					};
					src[wr.req[s].rd2] <= '{
						in_rf: 1'b0,
						half:  1'b1,
						tag:   wr.req[s].tag
					};
				end
			end

			if (wr.flush) begin
				for (int r = 0; r < `RN_AREGS; r++)
					src[r] <= rename_pkg::RF_ENTRY;
			end

			// hard-wired registers never wait on a tag
			src[0] <= rename_pkg::RF_ENTRY;
			src[`RN_ZERO_B] <= rename_pkg::RF_ENTRY;
		end
	end

	// ==============================
	// read ports
	// ==============================
	always_comb begin
		for (int p = 0; p < `RN_RD_PORTS; p++) begin
			rd.in_rf[p] = src[rd.addr[p]].in_rf;
			rd.half[p] = src[rd.addr[p]].half;
			rd.tag[p] = src[rd.addr[p]].tag;
		end
	end

	a_zero_regs: assert property (@(posedge clk) disable iff (rst)
		src[0].in_rf && src[`RN_ZERO_B].in_rf)
		else $error("hard-wired register lost in_rf");

endmodule

// File: rtl/operand_lookup.sv
// ==============================
// operand source lookup
// drives the map read addresses and registers
// each returned entry for the execute stage
// ==============================
`timescale 1ns/1ps
`include "rename_cfg.svh"

module operand_lookup (
	input  logic                         clk,
	input  logic                         rst,
	input  rename_pkg::areg_t            rd_addr [`RN_RD_PORTS],
	output logic [`RN_RD_PORTS-1:0]      rd_in_rf,
	output logic [`RN_RD_PORTS-1:0]      rd_half,
	output rename_pkg::rob_tag_t         rd_tag  [`RN_RD_PORTS],
	map_read_if.lookup                   rd
);

	// addresses go straight to the table, results come back the same cycle
	always_comb begin
		for (int p = 0; p < `RN_RD_PORTS; p++)
			rd.addr[p] = rd_addr[p];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_in_rf <= '1;
			rd_half <= '0;
		end else begin
			rd_in_rf <= rd.in_rf;
			rd_half <= rd.half;
		end
		// the tag is payload and only meaningful while in_rf is clear
		for (int p = 0; p < `RN_RD_PORTS; p++)
			rd_tag[p] <= rd.tag[p];
	end

	// ==============================
	// checks
	// ==============================
	// the table clears half whenever a register returns to the
	// register file, so a ready operand never carries the half bit
	a_ready_half: assert property (@(posedge clk) disable iff (rst)
		(rd_in_rf & rd_half) == '0)
		else $error("rd_half set on in_rf operand, in_rf %b half %b",
			rd_in_rf, rd_half);

endmodule

// File: rtl/rename_top.sv
// ==============================
// register rename stage top level
// plain ports in, tagger feeds the rename map,
// operand lookup reads it back out
// ==============================
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`RN_SLOTS-1:0]    slot_valid,
	input  logic [`RN_SLOTS-1:0]    slot_queued,
	input  logic [`RN_SLOTS-1:0]    slot_rfw,
	input  rename_pkg::areg_t       slot_rd  [`RN_SLOTS],
	input  rename_pkg::areg_t       slot_rd2 [`RN_SLOTS],
	input  rename_pkg::rob_tag_t    rob_tail,
	output logic [2:0]              dispatch_count,
	input  logic                    commit_valid,
	input  rename_pkg::rob_tag_t    commit_tag,
	input  logic                    flush,
	input  rename_pkg::areg_t       rd_addr [`RN_RD_PORTS],
	output logic [`RN_RD_PORTS-1:0] rd_in_rf,
	output logic [`RN_RD_PORTS-1:0] rd_half,
	output rename_pkg::rob_tag_t    rd_tag  [`RN_RD_PORTS]
);

	dispatch_pkg::slot_t slots [`RN_SLOTS];

	map_write_if wr_if ();
	map_read_if  rd_if ();

	always_comb begin
		for (int i = 0; i < `RN_SLOTS; i++) begin
			slots[i].valid = slot_valid[i];
			slots[i].queued = slot_queued[i];
			slots[i].rfw = slot_rfw[i];
			slots[i].rd = slot_rd[i];
			slots[i].rd2 = slot_rd2[i];
		end
	end

	dispatch_tagger u_tagger (
		.clk            (clk),
		.rst            (rst),
		.flush          (flush),
		.slots          (slots),
		.rob_tail       (rob_tail),
		.dispatch_count (dispatch_count),
		.wr             (wr_if.tagger)
	);

	rename_map u_map (
		.clk          (clk),
		.rst          (rst),
		.commit_valid (commit_valid),
		.commit_tag   (commit_tag),
		.wr           (wr_if.map),
		.rd           (rd_if.map)
	);

	operand_lookup u_lookup (
		.clk      (clk),
		.rst      (rst),
		.rd_addr  (rd_addr),
		.rd_in_rf (rd_in_rf),
		.rd_half  (rd_half),
		.rd_tag   (rd_tag),
		.rd       (rd_if.lookup)
	);

endmodule

// File: dv/rename_tb.sv
// ==============================
// testbench for the rename stage
// a table model predicts every output
// and concurrent assertions compare them
// ==============================
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_tb;

	logic                    clk;
	logic                    rst;
	logic [`RN_SLOTS-1:0]    slot_valid;
	logic [`RN_SLOTS-1:0]    slot_queued;
	logic [`RN_SLOTS-1:0]    slot_rfw;
	rename_pkg::areg_t       slot_rd  [`RN_SLOTS];
	rename_pkg::areg_t       slot_rd2 [`RN_SLOTS];
	rename_pkg::rob_tag_t    rob_tail;
	logic [2:0]              dispatch_count;
	logic                    commit_valid;
	rename_pkg::rob_tag_t    commit_tag;
	logic                    flush;
	rename_pkg::areg_t       rd_addr [`RN_RD_PORTS];
	logic [`RN_RD_PORTS-1:0] rd_in_rf;
	logic [`RN_RD_PORTS-1:0] rd_half;
	rename_pkg::rob_tag_t    rd_tag  [`RN_RD_PORTS];

	// model of the table and of the tagger stage
	rename_pkg::src_entry_t  model [`RN_AREGS];
	dispatch_pkg::map_wr_t   pend  [`RN_SLOTS];
	logic [2:0]              exp_count;
	logic [`RN_RD_PORTS-1:0] exp_in_rf;
	logic [`RN_RD_PORTS-1:0] exp_half;
	rename_pkg::rob_tag_t    exp_tag [`RN_RD_PORTS];
	int                      errors;
	int                      timeouts;
	logic [15:0]             lfsr;

	rename_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic rename_pkg::src_entry_t free_entry();
		return '{in_rf: 1'b1, half: 1'b0, tag: '0};
	endfunction

	// Galois LFSR, one step per bit taken
	function automatic logic rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hB400 : 16'h0000);
		return b;
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[6:0], rand_bit()};
		return v;
	endfunction

	// ==============================
	// reference model
	// ==============================
	always @(posedge clk) begin : model_step
		rename_pkg::src_entry_t nxt [`RN_AREGS];
		dispatch_pkg::map_wr_t  nxt_pend [`RN_SLOTS];
		logic [2:0]             rank;
		logic                   blocked;
		if (rst) begin
			for (int r = 0; r < `RN_AREGS; r++)
				model[r] <= free_entry();
			for (int s = 0; s < `RN_SLOTS; s++)
				pend[s] <= '0;
			exp_count <= '0;
			exp_in_rf <= '1;
			exp_half <= '0;
		end else begin
			// operand reads see the table as it stood before this edge
			for (int p = 0; p < `RN_RD_PORTS; p++) begin
				exp_in_rf[p] <= model[rd_addr[p]].in_rf;
				exp_half[p] <= model[rd_addr[p]].half;
				exp_tag[p] <= model[rd_addr[p]].tag;
			end
			nxt = model;
			if (commit_valid) begin
				for (int r = 0; r < `RN_AREGS; r++)
					if (!nxt[r].in_rf && nxt[r].tag == commit_tag)
						nxt[r] = free_entry();
			end
			for (int s = 0; s < `RN_SLOTS; s++) begin
				if (pend[s].en) begin
					nxt[pend[s].rd] = '{in_rf: 1'b0, half: 1'b0, tag: pend[s].tag};
					if (pend[s].rd2 != '0)
						nxt[pend[s].rd2] = '{in_rf: 1'b0, half: 1'b1, tag: pend[s].tag};
				end
			end
			if (flush)
				for (int r = 0; r < `RN_AREGS; r++)
					nxt[r] = free_entry();
			nxt[0] = free_entry();
			nxt[`RN_ZERO_B] = free_entry();
			model <= nxt;

			// the k-th accepted slot takes rob_tail plus k
			rank = '0;
			blocked = 1'b0;
			for (int s = 0; s < `RN_SLOTS; s++) begin
				nxt_pend[s] = '{en: 1'b0, rd: slot_rd[s], rd2: slot_rd2[s],
					tag: rob_tail + rename_pkg::rob_tag_t'(rank)};
				if (slot_valid[s] && !blocked && !slot_queued[s])
					blocked = 1'b1;
				if (slot_valid[s] && !blocked) begin
					nxt_pend[s].en = slot_rfw[s] && !flush;
					rank = rank + 3'd1;
				end
			end
			pend <= nxt_pend;
			exp_count <= flush ? 3'd0 : rank;
		end
	end

	// ==============================
	// output checks
	// ==============================
	a_count: assert property (@(posedge clk) disable iff (rst) dispatch_count == exp_count)
		else begin
			errors++;
			$display("ERR dispatch_count exp %h got %h", $sampled(exp_count),
				$sampled(dispatch_count));
		end

	for (genvar p = 0; p < `RN_RD_PORTS; p++) begin : g_port
		a_in_rf: assert property (@(posedge clk) disable iff (rst)
			rd_in_rf[p] == exp_in_rf[p])
			else begin
				errors++;
				$display("ERR rd_in_rf[%0d] exp %h got %h", p, $sampled(exp_in_rf[p]),
					$sampled(rd_in_rf[p]));
			end
		a_half: assert property (@(posedge clk) disable iff (rst) rd_half[p] == exp_half[p])
			else begin
				errors++;
				$display("ERR rd_half[%0d] exp %h got %h", p, $sampled(exp_half[p]),
					$sampled(rd_half[p]));
			end
		// the tag only means something while the operand is pending
		a_tag: assert property (@(posedge clk) disable iff (rst)
			exp_in_rf[p] || rd_tag[p] == exp_tag[p])
			else begin
				errors++;
				$display("ERR rd_tag[%0d] exp %h got %h", p, $sampled(exp_tag[p]),
					$sampled(rd_tag[p]));
			end
	end

	// ==============================
	// stimulus helpers
	// ==============================
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic clear_slots();
		slot_valid = '0;
		slot_queued = '0;
		slot_rfw = '0;
		for (int s = 0; s < `RN_SLOTS; s++) begin
			slot_rd[s] = '0;
			slot_rd2[s] = '0;
		end
	endtask

	task automatic set_slot(input int s, input logic q, input rename_pkg::areg_t rd,
		input rename_pkg::areg_t rd2);
		slot_valid[s] = 1'b1;
		slot_queued[s] = q;
		slot_rfw[s] = 1'b1;
		slot_rd[s] = rd;
		slot_rd2[s] = rd2;
	endtask

	task automatic read_regs(input rename_pkg::areg_t a0, input rename_pkg::areg_t a1);
		rd_addr[0] = a0;
		rd_addr[1] = a1;
		tick();
	endtask

	task automatic sweep_reads();
		for (int k = 0; k < `RN_AREGS / 2; k++)
			read_regs(rename_pkg::areg_t'(2 * k), rename_pkg::areg_t'(2 * k + 1));
	endtask

	task automatic random_slots(input logic with_rd2);
		for (int s = 0; s < `RN_SLOTS; s++) begin
			slot_valid[s] = rand_bit();
			slot_queued[s] = rand_bit() | rand_bit();
			slot_rfw[s] = rand_bit() | rand_bit();
			slot_rd[s] = rename_pkg::areg_t'(rand_bits(6));
			slot_rd2[s] = with_rd2 ? rename_pkg::areg_t'(rand_bits(6)) : '0;
		end
		rd_addr[0] = rename_pkg::areg_t'(rand_bits(6));
		rd_addr[1] = rename_pkg::areg_t'(rand_bits(6));
	endtask

	task automatic wait_count(input logic [2:0] want, input int limit);
		int n;
		n = 0;
		while (dispatch_count !== want && n < limit) begin
			tick();
			n++;
		end
		if (dispatch_count !== want) begin
			timeouts++;
			$display("timeout waiting for dispatch_count to reach %0d", want);
		end
	endtask

	task automatic wait_reset_done(input int limit);
		int n;
		n = 0;
		while (rd_in_rf !== '1 && n < limit) begin
			tick();
			n++;
		end
		if (rd_in_rf !== '1) begin
			timeouts++;
			$display("timeout waiting for the operand ports to leave reset");
		end
	endtask

	// ==============================
	// test sequence
	// ==============================
	initial begin : stimulus
		lfsr = 16'd78;
		errors = 0;
		timeouts = 0;
		rst = 1'b1;
		clear_slots();
		rob_tail = '0;
		commit_valid = 1'b0;
		commit_tag = '0;
		flush = 1'b0;
		rd_addr[0] = '0;
		rd_addr[1] = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		wait_reset_done(8);
		sweep_reads();

		// four slots starting at tail 62 wrap to tags 0 and 1
		rob_tail = 6'd62;
		for (int s = 0; s < `RN_SLOTS; s++)
			set_slot(s, 1'b1, rename_pkg::areg_t'(5 + s), '0);
		tick();
		clear_slots();
		wait_count(3'd4, 4);
		tick();
		read_regs(6'd5, 6'd6);
		read_regs(6'd7, 6'd8);
		for (int i = 0; i < 24; i++) begin
			random_slots(1'b0);
			rob_tail = rename_pkg::rob_tag_t'(rand_bits(6));
			tick();
		end
		clear_slots();

		// second destinations, a collision on r10 and the hard-wired registers
		rob_tail = 6'd20;
		set_slot(0, 1'b1, 6'd10, 6'd11);
		set_slot(1, 1'b1, 6'd10, 6'd32);
		set_slot(2, 1'b1, 6'd0, 6'd12);
		tick();
		clear_slots();
		wait_count(3'd3, 4);
		tick();
		read_regs(6'd10, 6'd11);
		read_regs(6'd12, 6'd32);
		read_regs(6'd0, 6'd10);

		// r21 is remapped to tag 42 before tag 41 commits
		rob_tail = 6'd40;
		set_slot(0, 1'b1, 6'd20, '0);
		set_slot(1, 1'b1, 6'd21, '0);
		tick();
		rob_tail = 6'd42;
		clear_slots();
		set_slot(0, 1'b1, 6'd21, '0);
		tick();
		clear_slots();
		tick();
		commit_valid = 1'b1;
		commit_tag = 6'd41;
		read_regs(6'd20, 6'd21);
		commit_tag = 6'd40;
		read_regs(6'd20, 6'd21);
		commit_valid = 1'b0;
		read_regs(6'd20, 6'd21);
		read_regs(6'd20, 6'd21);

		// a map write and a commit of the same tag land on one edge
		rob_tail = 6'd50;
		set_slot(0, 1'b1, 6'd24, '0);
		tick();
		clear_slots();
		tick();
		set_slot(0, 1'b1, 6'd24, '0);
		tick();
		clear_slots();
		commit_valid = 1'b1;
		commit_tag = 6'd50;
		tick();
		commit_valid = 1'b0;
		read_regs(6'd24, 6'd24);
		read_regs(6'd24, 6'd24);

		// flush with slots pending and slots arriving in the same cycle
		for (int i = 0; i < 6; i++) begin
			random_slots(1'b1);
			rob_tail = rename_pkg::rob_tag_t'(rand_bits(6));
			tick();
		end
		random_slots(1'b1);
		flush = 1'b1;
		tick();
		flush = 1'b0;
		clear_slots();
		wait_count(3'd0, 2);
		sweep_reads();

		// mixed random traffic
		for (int i = 0; i < 300; i++) begin
			random_slots(1'b1);
			rob_tail = {2'b00, 4'(rand_bits(4))};
			commit_valid = rand_bit();
			commit_tag = {2'b00, 4'(rand_bits(4))};
			flush = (rand_bits(5) == 8'h1f);
			tick();
		end
		clear_slots();
		commit_valid = 1'b0;
		flush = 1'b0;
		tick();
		tick();

		$display("mismatches %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+rtl
rtl/rename_pkg.sv
rtl/dispatch_pkg.sv
rtl/rename_ifs.sv
rtl/dispatch_tagger.sv
rtl/rename_map.sv
rtl/operand_lookup.sv
rtl/rename_top.sv
dv/rename_tb.sv

// File: run.sh
#!/bin/sh
# build the rename stage testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module rename_tb -o rename_sim \
	&& ./obj_dir/rename_sim | tee sim.log \
	|| { echo "build or run error"; exit 1; }
grep -q "\*\*\* PASSED \*\*\*" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
